// File: hmac.sv
/*
  keyed-MAC accelerator top level
  register front end feeding the mixing core, with the
  key-vault client as a side stage on the front end
*/
`timescale 1ns/10ps

module hmac
  import hmac_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     cs,
  input  logic     we,
  input  addr_t    address,
  input  word_t    write_data,
  output word_t    read_data,
  output kv_req_t  kv_req,
  input  kv_resp_t kv_resp,
  output logic     notif_intr,
  output logic     error_intr
);

  // front end to core
  logic     init_cmd;
  logic     next_cmd;
  logic     ready;
  logic     tag_valid;
  word_t    key      [KEY_WORDS];
  word_t    block    [BLOCK_WORDS];
  word_t    tag      [TAG_WORDS];

  // front end to vault client
  kv_ctrl_t kv_ctrl;
  word_t    dest_tag [TAG_WORDS];
  logic     dest_avail;
  kv_fill_t fill;
  logic     key_done;
  logic     src_done;
  logic     dest_done;
  logic     kv_err;

  hmac_regs regs0 (
    .clk, .reset_n, .cs, .we, .address, .write_data, .read_data,
    .init_cmd, .next_cmd, .key, .block, .ready, .tag_valid, .tag,
    .kv_ctrl, .dest_tag, .dest_avail, .fill,
    .key_done, .src_done, .dest_done, .kv_err,
    .notif_intr, .error_intr
  );

  hmac_mix_core core0 (
    .clk, .reset_n, .init_cmd, .next_cmd, .key, .block,
    .ready, .tag_valid, .tag
  );

  hmac_kv_client kv0 (
    .clk, .reset_n, .kv_ctrl, .dest_tag, .dest_avail,
    .kv_req, .kv_resp, .fill,
    .key_done, .src_done, .dest_done, .kv_err
  );

endmodule

// File: hmac_assert.sv
/*
  keyed-MAC accelerator bound checks
  four-phase vault handshake rules and the command rule
  of the mixing core, seen from the top level
*/
`timescale 1ns/10ps

module hmac_assert
  import hmac_pkg::*;
(
  input logic     clk,
  input logic     reset_n,
  input kv_req_t  kv_req,
  input kv_resp_t kv_resp,
  input logic     ready
);

  // ----------------------------------------------------------
  // vault handshake
  // ----------------------------------------------------------
  // request fields held until the vault answers
  req_stable: assert property (@(posedge clk) disable iff (!reset_n)
    kv_req.req && !kv_resp.ack |=> $stable(kv_req))
    else $error("vault request changed before ack");

  // new req only once the previous ack is gone
  req_after_ack: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(kv_req.req) |-> !$past(kv_resp.ack))
    else $error("vault request raised while ack still high");

  // ----------------------------------------------------------
  // core commands
  // ----------------------------------------------------------
  // a busy run is never restarted and lasts exactly one block
  busy_length: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(ready) |-> ##BLOCK_WORDS ready)
    else $error("core run restarted or overran while busy");

endmodule

bind hmac hmac_assert assert0 (
  .clk, .reset_n, .kv_req, .kv_resp, .ready
);

// File: hmac_kv_client.sv
/*
  key-vault client
  four-phase master that copies key and block words in from
  the vault and stores a finished tag back to a chosen entry
*/
`timescale 1ns/10ps

module hmac_kv_client
  import hmac_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  kv_ctrl_t kv_ctrl,
  input  word_t    dest_tag [TAG_WORDS],
  input  logic     dest_avail,
  output kv_req_t  kv_req,
  input  kv_resp_t kv_resp,
  output kv_fill_t fill,
  output logic     key_done,
  output logic     src_done,
  output logic     dest_done,
  output logic     kv_err
);

  typedef enum logic [1:0] {KV_IDLE, KV_REQ, KV_WAIT} kv_state_t;
  typedef enum logic [1:0] {OP_KEY, OP_SRC, OP_DEST} kv_op_t;

  kv_state_t state_q;
  kv_op_t    op_q;
  logic      dest_pend_q;
  logic      stop_q;
  kv_off_t   last_off;

  // last word offset of the running transfer
  always_comb
  begin
    case (op_q)
      OP_KEY:  last_off = kv_off_t'(KEY_WORDS - 1);
      OP_SRC:  last_off = kv_off_t'(BLOCK_WORDS - 1);
      default: last_off = kv_off_t'(TAG_WORDS - 1);
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q     <= KV_IDLE;
      op_q        <= OP_KEY;
      dest_pend_q <= 1'b0;
      stop_q      <= 1'b0;
      kv_req      <= '0;
      fill        <= '0;
      key_done    <= 1'b0;
      src_done    <= 1'b0;
      dest_done   <= 1'b0;
      kv_err      <= 1'b0;
    end
    else
    begin
      // single-cycle pulses
      fill.en   <= 1'b0;
      key_done  <= 1'b0;
      src_done  <= 1'b0;
      dest_done <= 1'b0;
      kv_err    <= 1'b0;

      case (state_q)
        // key first, then src, then a pending store
        KV_IDLE:
        begin
          stop_q        <= 1'b0;
          kv_req.offset <= '0;
          if (kv_ctrl.key_sel_en && !kv_ctrl.key_done)
          begin
            op_q         <= OP_KEY;
            kv_req.req   <= 1'b1;
            kv_req.write <= 1'b0;
            kv_req.entry <= kv_ctrl.key_entry;
            state_q      <= KV_REQ;
          end
          else if (kv_ctrl.src_sel_en && !kv_ctrl.src_done)
          begin
            op_q         <= OP_SRC;
            kv_req.req   <= 1'b1;
            kv_req.write <= 1'b0;
            kv_req.entry <= kv_ctrl.src_entry;
            state_q      <= KV_REQ;
          end
          else if (dest_pend_q)
          begin
            op_q         <= OP_DEST;
            dest_pend_q  <= 1'b0;
            kv_req.req   <= 1'b1;
            kv_req.write <= 1'b1;
            kv_req.entry <= kv_ctrl.dest_entry;
            kv_req.wdata <= dest_tag[0];
            state_q      <= KV_REQ;
          end
        end

        // fields held until the vault acks
        KV_REQ:
        begin
          if (kv_resp.ack)
          begin
            kv_req.req <= 1'b0;
            state_q    <= KV_WAIT;
            if (kv_resp.err)
            begin
              // abort, no done for this transfer
              kv_err <= 1'b1;
              stop_q <= 1'b1;
            end
            else
            begin
              fill.en     <= (op_q != OP_DEST);
              fill.is_key <= (op_q == OP_KEY);
              fill.offset <= kv_req.offset;
              fill.data   <= kv_resp.rdata;
              // done goes out early so sel_en is cleared before idle
              if (kv_req.offset == last_off)
              begin
                stop_q    <= 1'b1;
                key_done  <= (op_q == OP_KEY);
                src_done  <= (op_q == OP_SRC);
                dest_done <= (op_q == OP_DEST);
              end
            end
          end
        end

        // vault must drop ack before the next req
        KV_WAIT:
        begin
          if (!kv_resp.ack)
          begin
            if (stop_q)
              state_q <= KV_IDLE;
            else
            begin
              kv_req.offset <= kv_req.offset + 3'd1;
              kv_req.wdata  <= dest_tag[kv_req.offset[1:0] + 2'd1];
              kv_req.req    <= 1'b1;
              state_q       <= KV_REQ;
            end
          end
        end

        default: state_q <= KV_IDLE;
      endcase

      // new tag to store, kept until served
      if (dest_avail)
        dest_pend_q <= 1'b1;
    end
  end

endmodule

// File: hmac_mix_core.sv
/*
  keyed mixing core
  iterative stand-in for the hash compression with an
  init/next/ready/tag_valid contract, one block word per cycle
*/
`timescale 1ns/10ps

module hmac_mix_core
  import hmac_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  init_cmd,
  input  logic  next_cmd,
  input  word_t key   [KEY_WORDS],
  input  word_t block [BLOCK_WORDS],
  output logic  ready,
  output logic  tag_valid,
  output word_t tag   [TAG_WORDS]
);

  typedef enum logic {MIX_IDLE, MIX_RUN} mix_state_t;

  mix_state_t state_q;
  logic [2:0] step_q;
  logic [1:0] widx;
  logic       accept;
  word_t      st_q [TAG_WORDS];
  word_t      sum;

  assign ready  = (state_q == MIX_IDLE);
  // commands are dropped while busy
  assign accept = ready & (init_cmd | next_cmd);
  // state word touched by this step
  assign widx   = step_q[1:0];
  assign sum    = st_q[widx] + block[step_q];

  // ----------------------------------------------------------
  // step sequencing
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q   <= MIX_IDLE;
      step_q    <= '0;
      tag_valid <= 1'b0;
    end
    else if (accept)
    begin
      state_q   <= MIX_RUN;
      step_q    <= '0;
      tag_valid <= 1'b0;
    end
    else if (state_q == MIX_RUN)
    begin
      step_q <= step_q + 3'd1;
      // last block word brings up tag and ready together
      if (step_q == 3'(BLOCK_WORDS - 1))
      begin
        state_q   <= MIX_IDLE;
        tag_valid <= 1'b1;
      end
    end
  end

  // next keeps the previous chaining state
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < TAG_WORDS; i++)
        st_q[i] <= '0;
    end
    else if (accept && init_cmd)
    begin
      for (int i = 0; i < TAG_WORDS; i++)
        st_q[i] <= key[i] ^ IPAD_WORD;
    end
    else if (state_q == MIX_RUN)
    begin
      // rotate left and fold in the neighbour word
      st_q[widx] <= ((sum << MIX_ROT) | (sum >> (32 - MIX_ROT))) ^ st_q[widx + 2'd1];
    end
  end

  // outer pad applied on the way out
  always_comb
  begin
    for (int i = 0; i < TAG_WORDS; i++)
      tag[i] = st_q[i] ^ key[i] ^ OPAD_WORD;
  end

endmodule

// File: hmac_pkg.sv
/*
  keyed-MAC accelerator shared definitions
  word types, register map, control bit positions, pad constants
  and the key-vault request, response and fill structs
*/
package hmac_pkg;

  // ----------------------------------------------------------
  // word and index types
  // ----------------------------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [7:0]  addr_t;
  typedef logic [2:0]  kv_entry_t;
  typedef logic [2:0]  kv_off_t;

  // sizes in 32-bit words
  localparam int KEY_WORDS   = 4;
  localparam int BLOCK_WORDS = 8;
  localparam int TAG_WORDS   = 4;
  // rotate amount of one mixing step
  localparam int MIX_ROT     = 7;

  localparam word_t IPAD_WORD = 32'h3636_3636;
  localparam word_t OPAD_WORD = 32'h5c5c_5c5c;
  // ascii "HMAC"
  localparam word_t CORE_NAME = 32'h484d_4143;

  // ----------------------------------------------------------
  // register map
  // ----------------------------------------------------------
  localparam addr_t ADDR_CTRL    = 8'h00;
  localparam addr_t ADDR_STATUS  = 8'h04;
  localparam addr_t ADDR_KV_CTRL = 8'h08;
  localparam addr_t ADDR_INTR    = 8'h0c;
  localparam addr_t ADDR_KEY0    = 8'h10;
  localparam addr_t ADDR_BLOCK0  = 8'h20;
  localparam addr_t ADDR_TAG0    = 8'h40;
  localparam addr_t ADDR_NAME    = 8'h50;

  // bit positions
  localparam int CTRL_INIT_BIT      = 0;
  localparam int CTRL_NEXT_BIT      = 1;
  localparam int STATUS_READY_BIT   = 0;
  localparam int STATUS_VALID_BIT   = 1;
  localparam int INTR_NOTIF_STS_BIT = 0;
  localparam int INTR_NOTIF_EN_BIT  = 1;
  localparam int INTR_ERR_STS_BIT   = 2;
  localparam int INTR_ERR_EN_BIT    = 3;

  // software writable part of KV_CTRL, done bits are hardware set
  localparam word_t KV_CTRL_WMASK = 32'h0000_0fff;

  // ----------------------------------------------------------
  // key-vault structs
  // ----------------------------------------------------------
  // laid out to match the KV_CTRL register word
  typedef struct packed {
    logic [12:0] rsvd_hi;
    logic        dest_done;
    logic        src_done;
    logic        key_done;
    logic [3:0]  rsvd_lo;
    kv_entry_t   dest_entry;
    logic        dest_en;
    kv_entry_t   src_entry;
    logic        src_sel_en;
    kv_entry_t   key_entry;
    logic        key_sel_en;
  } kv_ctrl_t;

  typedef struct packed {
    logic      req;
    logic      write;
    kv_entry_t entry;
    kv_off_t   offset;
    word_t     wdata;
  } kv_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    word_t rdata;
  } kv_resp_t;

  // one fetched word headed for the key or block registers
  typedef struct packed {
    logic    en;
    logic    is_key;
    kv_off_t offset;
    word_t   data;
  } kv_fill_t;

endpackage

// File: hmac_regs.sv
/*
  register front end
  bus decode for control, status, key, block, tag and name,
  key-vault control with hardware done bits, tag store and
  the notification and error interrupt registers
*/
`timescale 1ns/10ps

module hmac_regs
  import hmac_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     cs,
  input  logic     we,
  input  addr_t    address,
  input  word_t    write_data,
  output word_t    read_data,
  output logic     init_cmd,
  output logic     next_cmd,
  output word_t    key      [KEY_WORDS],
  output word_t    block    [BLOCK_WORDS],
  input  logic     ready,
  input  logic     tag_valid,
  input  word_t    tag      [TAG_WORDS],
  output kv_ctrl_t kv_ctrl,
  output word_t    dest_tag [TAG_WORDS],
  output logic     dest_avail,
  input  kv_fill_t fill,
  input  logic     key_done,
  input  logic     src_done,
  input  logic     dest_done,
  input  logic     kv_err,
  output logic     notif_intr,
  output logic     error_intr
);

  word_t      tag_q [TAG_WORDS];
  logic       tag_valid_q;
  logic       tag_we;
  logic       wr;
  logic       rd;
  logic       key_hit;
  logic       block_hit;
  logic       tag_hit;
  logic [2:0] widx;
  logic       init_new;
  logic       next_new;
  logic       notif_sts_q;
  logic       notif_en_q;
  logic       err_sts_q;
  logic       err_en_q;
  kv_ctrl_t   kv_new;

  // ----------------------------------------------------------
  // address decode
  // ----------------------------------------------------------
  assign wr        = cs & we;
  assign rd        = cs & ~we;
  assign widx      = address[4:2];
  assign key_hit   = address inside {[ADDR_KEY0 : ADDR_KEY0 + addr_t'(4 * KEY_WORDS - 4)]};
  assign block_hit = address inside {[ADDR_BLOCK0 : ADDR_BLOCK0 + addr_t'(4 * BLOCK_WORDS - 4)]};
  assign tag_hit   = address inside {[ADDR_TAG0 : ADDR_TAG0 + addr_t'(4 * TAG_WORDS - 4)]};
  assign init_new  = wr && (address == ADDR_CTRL) && write_data[CTRL_INIT_BIT];
  assign next_new  = wr && (address == ADDR_CTRL) && write_data[CTRL_NEXT_BIT];

  // rising edge of tag_valid
  assign tag_we = tag_valid & ~tag_valid_q;

  // software view of a KV_CTRL write, setting a sel_en rearms it
  always_comb
  begin
    kv_new = kv_ctrl_t'((write_data & KV_CTRL_WMASK) | (word_t'(kv_ctrl) & ~KV_CTRL_WMASK));
    if (kv_new.key_sel_en)
      kv_new.key_done = 1'b0;
    if (kv_new.src_sel_en)
      kv_new.src_done = 1'b0;
  end

  // ----------------------------------------------------------
  // control and interrupt state
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      init_cmd    <= 1'b0;
      next_cmd    <= 1'b0;
      tag_valid_q <= 1'b0;
      dest_avail  <= 1'b0;
      kv_ctrl     <= '0;
      notif_sts_q <= 1'b0;
      notif_en_q  <= 1'b0;
      err_sts_q   <= 1'b0;
      err_en_q    <= 1'b0;
    end
    else
    begin
      init_cmd    <= init_new;
      next_cmd    <= next_new;
      tag_valid_q <= tag_valid;
      dest_avail  <= tag_we & kv_ctrl.dest_en;

      if (wr && (address == ADDR_KV_CTRL))
        kv_ctrl <= kv_new;
      // hardware updates win over the bus
      if (key_done)
      begin
        kv_ctrl.key_sel_en <= 1'b0;
        kv_ctrl.key_done   <= 1'b1;
      end
      if (src_done)
      begin
        kv_ctrl.src_sel_en <= 1'b0;
        kv_ctrl.src_done   <= 1'b1;
      end
      // failed fetch is not retried
      if (kv_err)
      begin
        kv_ctrl.key_sel_en <= 1'b0;
        kv_ctrl.src_sel_en <= 1'b0;
      end
      if (dest_done)
        kv_ctrl.dest_done <= 1'b1;
      if (next_new)
        kv_ctrl.dest_done <= 1'b0;

      // w1c status, a same-cycle hardware event still sets
      if (wr && (address == ADDR_INTR))
      begin
        notif_en_q <= write_data[INTR_NOTIF_EN_BIT];
        err_en_q   <= write_data[INTR_ERR_EN_BIT];
        if (write_data[INTR_NOTIF_STS_BIT])
          notif_sts_q <= 1'b0;
        if (write_data[INTR_ERR_STS_BIT])
          err_sts_q <= 1'b0;
      end
      if (tag_we)
        notif_sts_q <= 1'b1;
      if (kv_err)
        err_sts_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // key, block and tag storage
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < KEY_WORDS; i++)
        key[i] <= '0;
      for (int i = 0; i < BLOCK_WORDS; i++)
        block[i] <= '0;
      for (int i = 0; i < TAG_WORDS; i++)
      begin
        tag_q[i]    <= '0;
        dest_tag[i] <= '0;
      end
    end
    else
    begin
      if (wr && key_hit)
        key[widx[1:0]] <= write_data;
      if (wr && block_hit)
        block[widx] <= write_data;
      // vault fill last so it beats a bus write to the same word
      if (fill.en && fill.is_key)
        key[fill.offset[1:0]] <= fill.data;
      if (fill.en && !fill.is_key)
        block[fill.offset] <= fill.data;
      // finished tag goes either to software or to the vault staging copy
      if (tag_we && !kv_ctrl.dest_en)
        tag_q <= tag;
      if (tag_we && kv_ctrl.dest_en)
        dest_tag <= tag;
    end
  end

  // read mux, key and block are write only
  always_comb
  begin
    read_data = '0;
    if (rd)
    begin
      if (tag_hit)
        read_data = tag_q[widx[1:0]];
      else
      begin
        case (address)
          ADDR_STATUS:
          begin
            read_data[STATUS_READY_BIT] = ready;
            read_data[STATUS_VALID_BIT] = tag_valid;
          end
          ADDR_KV_CTRL: read_data = word_t'(kv_ctrl);
          ADDR_INTR:
          begin
            read_data[INTR_NOTIF_STS_BIT] = notif_sts_q;
            read_data[INTR_NOTIF_EN_BIT]  = notif_en_q;
            read_data[INTR_ERR_STS_BIT]   = err_sts_q;
            read_data[INTR_ERR_EN_BIT]    = err_en_q;
          end
          ADDR_NAME: read_data = CORE_NAME;
          default: read_data = '0;
        endcase
      end
    end
  end

  assign notif_intr = notif_sts_q & notif_en_q;
  assign error_intr = err_sts_q & err_en_q;

endmodule

// File: hmac_tb.sv
/*
  keyed-MAC accelerator testbench
  directed tests over the register bus, a four-phase vault
  model with random latency and a software model of the tag
*/
`timescale 1ns/10ps

module hmac_tb
  import hmac_pkg::*;
();

  logic     clk;
  logic     reset_n;
  logic     cs;
  logic     we;
  addr_t    address;
  word_t    write_data;
  word_t    read_data;
  kv_req_t  kv_req;
  kv_resp_t kv_resp = '0;
  logic     notif_intr;
  logic     error_intr;

  int       errors;
  int       timeouts;
  // vault contents with the entry in the upper address bits
  word_t    vault_mem [64];
  logic [5:0] vault_idx;
  int       vault_wait = 0;
  logic     vault_err;
  // software model state and the words loaded in the DUT
  word_t    ref_st    [TAG_WORDS];
  word_t    cur_key   [KEY_WORDS];
  word_t    cur_block [BLOCK_WORDS];

  hmac dut0 (
    .clk, .reset_n, .cs, .we, .address, .write_data, .read_data,
    .kv_req, .kv_resp, .notif_intr, .error_intr
  );

  always #2 clk = ~clk;

  // ----------------------------------------------------------
  // vault model
  // ----------------------------------------------------------
  always @(negedge clk)
  begin
    if (kv_resp.ack)
    begin
      // ack drops only after the client lets go
      if (!kv_req.req)
      begin
        kv_resp.ack = 1'b0;
        kv_resp.err = 1'b0;
        vault_wait  = int'($urandom % 6);
      end
    end
    else if (kv_req.req)
    begin
      if (vault_wait > 0)
        vault_wait--;
      else
      begin
        vault_idx = {kv_req.entry, kv_req.offset};
        if (kv_req.write)
          vault_mem[vault_idx] = kv_req.wdata;
        else
          kv_resp.rdata = vault_mem[vault_idx];
        kv_resp.err = vault_err;
        kv_resp.ack = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic word_t rotl(input word_t v, input int n);
    return (v << n) | (v >> (32 - n));
  endfunction

  task automatic start_chain();
    for (int i = 0; i < TAG_WORDS; i++)
      ref_st[i] = cur_key[i] ^ IPAD_WORD;
  endtask

  // one step per block word with the updated word seen by later steps
  task automatic mix_block();
    int    w;
    word_t sum;
    for (int j = 0; j < BLOCK_WORDS; j++)
    begin
      w         = j % 4;
      sum       = ref_st[w] + cur_block[j];
      ref_st[w] = rotl(sum, MIX_ROT) ^ ref_st[(w + 1) % 4];
    end
  endtask

  function automatic word_t expected_tag(input int i);
    return ref_st[i] ^ cur_key[i] ^ OPAD_WORD;
  endfunction

  // ----------------------------------------------------------
  // bus and check helpers
  // ----------------------------------------------------------
  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic bus_write(input addr_t a, input word_t d);
    @(negedge clk);
    cs         = 1'b1;
    we         = 1'b1;
    address    = a;
    write_data = d;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input addr_t a, output word_t d);
    @(negedge clk);
    cs      = 1'b1;
    we      = 1'b0;
    address = a;
    // combinational read data settles before sampling
    #1;
    d = read_data;
    @(negedge clk);
    cs = 1'b0;
  endtask

  // poll a register until all mask bits are set
  task automatic wait_bits(input addr_t a, input word_t mask, input string what);
    word_t d;
    int    polls;
    polls = 0;
    d     = '0;
    while ((d & mask) != mask && polls < 200)
    begin
      bus_read(a, d);
      polls++;
    end
    if ((d & mask) != mask)
    begin
      timeouts++;
      $display("Timeout waiting for %s", what);
    end
  endtask

  task automatic wait_tag();
    wait_bits(ADDR_STATUS, 32'h2, "tag_valid");
  endtask

  task automatic load_key();
    for (int i = 0; i < KEY_WORDS; i++)
      bus_write(addr_t'(ADDR_KEY0 + 4 * i), cur_key[i]);
  endtask

  task automatic load_block();
    for (int i = 0; i < BLOCK_WORDS; i++)
      bus_write(addr_t'(ADDR_BLOCK0 + 4 * i), cur_block[i]);
  endtask

  task automatic check_tag();
    word_t d;
    for (int i = 0; i < TAG_WORDS; i++)
    begin
      bus_read(addr_t'(ADDR_TAG0 + 4 * i), d);
      check($sformatf("tag[%0d]", i), d, expected_tag(i));
    end
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic reset_values();
    word_t d;
    bus_read(ADDR_STATUS, d);
    check("status", d, 32'h1);
    bus_read(ADDR_NAME, d);
    check("name", d, 32'h484d_4143);
    bus_read(ADDR_INTR, d);
    check("intr", d, 32'h0);
    check("notif_intr", 32'(notif_intr), 32'h0);
    check("error_intr", 32'(error_intr), 32'h0);
    check("kv_req.req", 32'(kv_req.req), 32'h0);
  endtask

  task automatic bus_key_init();
    load_key();
    load_block();
    bus_write(ADDR_CTRL, 32'h1);
    start_chain();
    mix_block();
    wait_tag();
    check_tag();
  endtask

  // second block chains and an init while busy is dropped
  task automatic next_chaining();
    foreach (cur_block[i])
      cur_block[i] = $urandom;
    load_block();
    bus_write(ADDR_CTRL, 32'h2);
    bus_write(ADDR_CTRL, 32'h1);
    mix_block();
    wait_tag();
    check_tag();
  endtask

  // key from entry 2 and block from entry 5
  task automatic vault_fetch();
    word_t d;
    bus_write(ADDR_KV_CTRL, 32'h1 | (32'd2 << 1) | 32'h10 | (32'd5 << 5));
    wait_bits(ADDR_KV_CTRL, 32'h0003_0000, "key and src done");
    bus_read(ADDR_KV_CTRL, d);
    check("kv_ctrl sel_en", d & 32'h11, 32'h0);
    for (int i = 0; i < KEY_WORDS; i++)
      cur_key[i] = vault_mem[2 * 8 + i];
    for (int i = 0; i < BLOCK_WORDS; i++)
      cur_block[i] = vault_mem[5 * 8 + i];
    bus_write(ADDR_CTRL, 32'h1);
    start_chain();
    mix_block();
    wait_tag();
    check_tag();
  endtask

  // tag stored to entry 6 with the software copy untouched
  task automatic vault_store();
    word_t old_tag [TAG_WORDS];
    word_t d;
    for (int i = 0; i < TAG_WORDS; i++)
      old_tag[i] = expected_tag(i);
    bus_write(ADDR_KV_CTRL, 32'h100 | (32'd6 << 9));
    bus_write(ADDR_CTRL, 32'h2);
    mix_block();
    wait_bits(ADDR_KV_CTRL, 32'h0004_0000, "dest done");
    for (int i = 0; i < TAG_WORDS; i++)
    begin
      check($sformatf("vault[6][%0d]", i), vault_mem[6 * 8 + i], expected_tag(i));
      bus_read(addr_t'(ADDR_TAG0 + 4 * i), d);
      check($sformatf("tag[%0d]", i), d, old_tag[i]);
    end
    bus_write(ADDR_KV_CTRL, 32'h0);
  endtask

  task automatic interrupts();
    word_t d;
    // enable notif and clear stale status
    bus_write(ADDR_INTR, 32'h3);
    check("notif_intr", 32'(notif_intr), 32'h0);
    bus_write(ADDR_CTRL, 32'h1);
    start_chain();
    mix_block();
    wait_tag();
    bus_read(ADDR_INTR, d);
    check("intr notif status", d & 32'h1, 32'h1);
    check("notif_intr", 32'(notif_intr), 32'h1);
    check_tag();
    bus_write(ADDR_INTR, 32'h3);
    check("notif_intr", 32'(notif_intr), 32'h0);

    // failing key fetch from entry 1
    vault_err = 1'b1;
    bus_write(ADDR_INTR, 32'h8);
    bus_write(ADDR_KV_CTRL, 32'h1 | (32'd1 << 1));
    wait_bits(ADDR_INTR, 32'h4, "error status");
    check("error_intr", 32'(error_intr), 32'h1);
    bus_read(ADDR_KV_CTRL, d);
    check("kv_ctrl key bits", d & 32'h0001_0001, 32'h0);
    vault_err = 1'b0;
    bus_write(ADDR_INTR, 32'hc);
    check("error_intr", 32'(error_intr), 32'h0);
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial
  begin
    void'($urandom(32'hbce1_390e));
    errors     = 0;
    timeouts   = 0;
    clk        = 1'b0;
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    vault_err  = 1'b0;
    foreach (vault_mem[i])
      vault_mem[i] = $urandom;
    foreach (cur_key[i])
      cur_key[i] = $urandom;
    foreach (cur_block[i])
      cur_block[i] = $urandom;

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    reset_values();
    bus_key_init();
    next_chaining();
    vault_fetch();
    vault_store();
    interrupts();

    $display("Done: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator and run, pass only if the testbench reports it
cd "$(dirname "$0")" \
  && verilator --binary --assert --top-module hmac_tb -f src.f -o hmac_sim \
  && ./obj_dir/hmac_sim | tee /dev/stderr | grep -qx "Test passed" \
  || { echo "simulation did not pass"; exit 1; }

// File: src.f
hmac_pkg.sv
hmac_mix_core.sv
hmac_kv_client.sv
hmac_regs.sv
hmac.sv
hmac_assert.sv
hmac_tb.sv
